// File: verilog/cdc_cfg.svh
`ifndef CDC_CFG_SVH
`define CDC_CFG_SVH

// Width of one data word on every channel
`define CDC_DATA_W 8

// Words per FIFO, must stay a power of two
`define CDC_FIFO_DEPTH 16

// log2 of the depth, RAM address bits
`define CDC_ADDR_W 4

`endif

// File: verilog/cdc_pkg.sv
`default_nettype none

`include "cdc_cfg.svh"

package cdc_pkg;

	// One payload byte
	typedef logic [`CDC_DATA_W-1:0] data_t;

	// RAM word address
	typedef logic [`CDC_ADDR_W-1:0] addr_t;

	// Pointer with one extra wrap bit, used for binary and Gray forms
	typedef logic [`CDC_ADDR_W:0] ptr_t;

	// Output channel tag
	typedef logic chan_t;

endpackage

`default_nettype wire

// File: verilog/dual_port_ram.sv
`timescale 1ns/1ps
`default_nettype none

`include "cdc_cfg.svh"

module dual_port_ram (
	input  wire            wclk,
	input  wire            wenc,
	input  cdc_pkg::addr_t waddr,
	input  cdc_pkg::data_t wdata,
	input  wire            rclk,
	input  wire            renc,
	input  cdc_pkg::addr_t raddr,
	output cdc_pkg::data_t rdata
);

	cdc_pkg::data_t mem [0:`CDC_FIFO_DEPTH-1];

	always_ff @(posedge wclk) begin
		if (wenc) begin
			mem[waddr] <= wdata;
		end
	end

	// Registered read port, holds the last word between pops
	always_ff @(posedge rclk) begin
		if (renc) begin
			rdata <= mem[raddr];
		end
	end

endmodule

`default_nettype wire

// File: verilog/async_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "cdc_cfg.svh"

module async_fifo (
	input  wire            wclk,
	input  wire            wrstn,
	input  wire            winc,
	input  cdc_pkg::data_t wdata,
	output logic           wfull,
	input  wire            rclk,
	input  wire            rrstn,
	input  wire            rinc,
	output logic           rempty,
	output cdc_pkg::data_t rdata
);

	// Write domain state
	cdc_pkg::ptr_t wbin;
	cdc_pkg::ptr_t wbin_next;
	cdc_pkg::ptr_t wgray;
	cdc_pkg::ptr_t wgray_next;
	cdc_pkg::ptr_t rptr_meta;
	cdc_pkg::ptr_t rptr_sync;
	cdc_pkg::ptr_t rptr_full_cmp;
	logic          wen;

	// Read domain state
	cdc_pkg::ptr_t rbin;
	cdc_pkg::ptr_t rgray;
	cdc_pkg::ptr_t wptr_meta;
	cdc_pkg::ptr_t wptr_sync;

	cdc_pkg::addr_t waddr;
	cdc_pkg::addr_t raddr;

	function automatic cdc_pkg::ptr_t bin2gray(input cdc_pkg::ptr_t bin);
		return bin ^ (bin >> 1);
	endfunction

	// Write side pointer arithmetic

	assign wen = winc & ~wfull; // Writes into a full FIFO are dropped
	assign wbin_next = wbin + cdc_pkg::ptr_t'(wen);
	assign wgray_next = bin2gray(wbin_next);
	assign waddr = wbin[`CDC_ADDR_W-1:0];

	always_ff @(posedge wclk or negedge wrstn) begin
		if (!wrstn) begin
			wbin <= '0;
			wgray <= '0;
		end else begin
			wbin <= wbin_next;
			wgray <= wgray_next;
		end
	end

	// Read pointer brought into wclk
	always_ff @(posedge wclk or negedge wrstn) begin
		if (!wrstn) begin
			rptr_meta <= '0;
			rptr_sync <= '0;
		end else begin
			rptr_meta <= rgray;
			rptr_sync <= rptr_meta;
		end
	end

	// Full when the next write pointer is one lap ahead of the read pointer
	assign rptr_full_cmp = {~rptr_sync[`CDC_ADDR_W:`CDC_ADDR_W-1],
		rptr_sync[`CDC_ADDR_W-2:0]};

	always_ff @(posedge wclk or negedge wrstn) begin
		if (!wrstn) begin
			wfull <= 1'b0;
		end else begin
			wfull <= (wgray_next == rptr_full_cmp); // Set on the edge storing the last slot
		end
	end

	// Read side pointer, rinc is already qualified by the arbiter

	assign raddr = rbin[`CDC_ADDR_W-1:0];

	always_ff @(posedge rclk or negedge rrstn) begin
		if (!rrstn) begin
			rbin <= '0;
			rgray <= '0;
		end else if (rinc) begin
			rbin <= rbin + cdc_pkg::ptr_t'(1);
			rgray <= bin2gray(rbin + cdc_pkg::ptr_t'(1));
		end
	end

	// Write pointer brought into rclk
	always_ff @(posedge rclk or negedge rrstn) begin
		if (!rrstn) begin
			wptr_meta <= '0;
			wptr_sync <= '0;
		end else begin
			wptr_meta <= wgray;
			wptr_sync <= wptr_meta;
		end
	end

	assign rempty = (rgray == wptr_sync);

	dual_port_ram u_ram (
		.wclk  (wclk),
		.wenc  (wen),
		.waddr (waddr),
		.wdata (wdata),
		.rclk  (rclk),
		.renc  (rinc),
		.raddr (raddr),
		.rdata (rdata)
	);

endmodule

`default_nettype wire

// File: verilog/rr_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module rr_arbiter (
	input  wire            rclk,
	input  wire            rrstn,
	input  wire            rempty0,
	input  wire            rempty1,
	input  cdc_pkg::data_t rdata0,
	input  cdc_pkg::data_t rdata1,
	output logic           rinc0,
	output logic           rinc1,
	input  wire            dout_hold,
	output logic           dout_vld,
	output cdc_pkg::data_t dout_data,
	output cdc_pkg::chan_t dout_chan
);

	logic           req0;
	logic           req1;
	logic           grant;
	cdc_pkg::chan_t sel;
	cdc_pkg::chan_t last_chan;

	assign req0 = ~rempty0;
	assign req1 = ~rempty1;

	// Pick a channel from the requests and the last served one
	always_comb begin
		if (req0 && req1) begin
			sel = ~last_chan; // Both waiting, serve the other one
		end else if (req1) begin
			sel = 1'b1;
		end else begin
			sel = 1'b0;
		end
	end

	// No pop while the sink holds
	assign grant = (req0 | req1) & ~dout_hold;

	assign rinc0 = grant & (sel == 1'b0);
	assign rinc1 = grant & (sel == 1'b1);

	// Output strobe follows the pop edge by one cycle
	always_ff @(posedge rclk or negedge rrstn) begin
		if (!rrstn) begin
			dout_vld <= 1'b0;
		end else begin
			dout_vld <= grant;
		end
	end

	always_ff @(posedge rclk or negedge rrstn) begin
		if (!rrstn) begin
			dout_chan <= 1'b0;
			last_chan <= 1'b1; // Channel 0 wins the first tie
		end else if (grant) begin
			dout_chan <= sel;
			last_chan <= sel;
		end
	end

	// RAM read registers were loaded on the pop edge
	assign dout_data = dout_chan ? rdata1 : rdata0;

endmodule

`default_nettype wire

// File: verilog/cdc_merge_top.sv
`timescale 1ns/1ps
`default_nettype none

module cdc_merge_top (
	input  wire            wclk,
	input  wire            wrstn,
	input  wire            winc0,
	input  cdc_pkg::data_t wdata0,
	output logic           wfull0,
	input  wire            winc1,
	input  cdc_pkg::data_t wdata1,
	output logic           wfull1,
	input  wire            rclk,
	input  wire            rrstn,
	input  wire            dout_hold,
	output logic           dout_vld,
	output cdc_pkg::data_t dout_data,
	output cdc_pkg::chan_t dout_chan
);

	logic           rinc0;
	logic           rinc1;
	logic           rempty0;
	logic           rempty1;
	cdc_pkg::data_t rdata0;
	cdc_pkg::data_t rdata1;

	async_fifo u_fifo0 (
		.wclk   (wclk),
		.wrstn  (wrstn),
		.winc   (winc0),
		.wdata  (wdata0),
		.wfull  (wfull0),
		.rclk   (rclk),
		.rrstn  (rrstn),
		.rinc   (rinc0),
		.rempty (rempty0),
		.rdata  (rdata0)
	);

	async_fifo u_fifo1 (
		.wclk   (wclk),
		.wrstn  (wrstn),
		.winc   (winc1),
		.wdata  (wdata1),
		.wfull  (wfull1),
		.rclk   (rclk),
		.rrstn  (rrstn),
		.rinc   (rinc1),
		.rempty (rempty1),
		.rdata  (rdata1)
	);

	// Merges both read sides into one tagged stream
	rr_arbiter u_arb (
		.rclk      (rclk),
		.rrstn     (rrstn),
		.rempty0   (rempty0),
		.rempty1   (rempty1),
		.rdata0    (rdata0),
		.rdata1    (rdata1),
		.rinc0     (rinc0),
		.rinc1     (rinc1),
		.dout_hold (dout_hold),
		.dout_vld  (dout_vld),
		.dout_data (dout_data),
		.dout_chan (dout_chan)
	);

endmodule

`default_nettype wire

// File: sim/tb_checks.svh
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// Stops the run at the first error
task automatic abort_run();
	$display("*** FAILED ***");
	$fatal(1, "simulation stopped at the first error");
endtask

task automatic compare_data(input string name, input cdc_pkg::data_t exp,
	input cdc_pkg::data_t act);
	if (act !== exp) begin
		$display("error at %0t ns: %s expected 0x%02h, got 0x%02h", $time, name, exp, act);
		abort_run();
	end
endtask

task automatic compare_chan(input string name, input cdc_pkg::chan_t exp,
	input cdc_pkg::chan_t act);
	if (act !== exp) begin
		$display("error at %0t ns: %s expected %0d, got %0d", $time, name, exp, act);
		abort_run();
	end
endtask

task automatic compare_flag(input string name, input logic exp, input logic act);
	if (act !== exp) begin
		$display("error at %0t ns: %s expected %b, got %b", $time, name, exp, act);
		abort_run();
	end
endtask

// Waits for the next output strobe, sampled in the middle of the read cycle
task automatic wait_for_vld(input int limit);
	int cycles;
	cycles = 0;
	do begin
		@(negedge rclk);
		cycles++;
	end while (!dout_vld && cycles < limit);
	if (!dout_vld) begin
		$display("timeout: no output word within %0d read cycles", limit);
		abort_run();
	end
endtask

`endif

// File: sim/tb_cdc_merge.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cdc_merge;

	localparam int SEED = 88;
	localparam int VLD_TIMEOUT = 40; // Read cycles allowed per output word
	localparam int IDLE_TIMEOUT = 200;
	localparam int DRAIN_CYCLES = 24;
	localparam int SYNC_SETTLE = 8; // Well past the pointer sync latency

	logic           wclk;
	logic           wrstn;
	logic           winc0;
	cdc_pkg::data_t wdata0;
	logic           wfull0;
	logic           winc1;
	cdc_pkg::data_t wdata1;
	logic           wfull1;
	logic           rclk;
	logic           rrstn;
	logic           dout_hold;
	logic           dout_vld;
	cdc_pkg::data_t dout_data;
	cdc_pkg::chan_t dout_chan;

	cdc_pkg::data_t q0[$]; // Accepted words per channel, in write order
	cdc_pkg::data_t q1[$];
	logic           wr_done;
	logic           rd_done;
	int unsigned    seed_val;

	`include "tb_checks.svh"

	cdc_merge_top DUT (
		.wclk      (wclk),
		.wrstn     (wrstn),
		.winc0     (winc0),
		.wdata0    (wdata0),
		.wfull0    (wfull0),
		.winc1     (winc1),
		.wdata1    (wdata1),
		.wfull1    (wfull1),
		.rclk      (rclk),
		.rrstn     (rrstn),
		.dout_hold (dout_hold),
		.dout_vld  (dout_vld),
		.dout_data (dout_data),
		.dout_chan (dout_chan)
	);

	always #50 rclk = ~rclk;
	always #35 wclk = ~wclk; // Unrelated to rclk

	// One wclk cycle on both channels, a word counts when wfull is low at the edge
	task automatic write_cycle(input logic en0, input cdc_pkg::data_t d0,
		input logic en1, input cdc_pkg::data_t d1);
		@(negedge wclk);
		winc0 = en0;
		wdata0 = d0;
		winc1 = en1;
		wdata1 = d1;
		if (en0 && !wfull0) begin
			q0.push_back(d0);
		end
		if (en1 && !wfull1) begin
			q1.push_back(d1);
		end
	endtask

	task automatic stop_writes();
		@(negedge wclk);
		winc0 = 1'b0;
		winc1 = 1'b0;
	endtask

	task automatic set_hold(input logic level);
		@(negedge rclk);
		dout_hold = level;
	endtask

	// Checks the word on the output against the head of its channel's queue
	task automatic take_word(input logic fixed_chan, input cdc_pkg::chan_t exp_chan);
		cdc_pkg::data_t exp_data;
		if (fixed_chan) begin
			compare_chan("dout_chan", exp_chan, dout_chan);
		end
		if ((dout_chan == 1'b0 && q0.size() == 0) || (dout_chan == 1'b1 && q1.size() == 0)) begin
			$display("channel %0d sent a word that was never written", dout_chan);
			abort_run();
		end else begin
			exp_data = dout_chan ? q1.pop_front() : q0.pop_front();
			compare_data("dout_data", exp_data, dout_data);
		end
	endtask

	task automatic expect_word(input logic fixed_chan, input cdc_pkg::chan_t exp_chan);
		wait_for_vld(VLD_TIMEOUT);
		take_word(fixed_chan, exp_chan);
	endtask

	task automatic expect_quiet(input int cycles);
		repeat (cycles) begin
			@(negedge rclk);
			compare_flag("dout_vld", 1'b0, dout_vld);
		end
	endtask

	task automatic check_idle_flags();
		compare_flag("wfull0", 1'b0, wfull0);
		compare_flag("wfull1", 1'b0, wfull1);
		compare_flag("dout_vld", 1'b0, dout_vld);
	endtask

	task automatic test_reset_state();
		$display("test: reset state");
		repeat (16) begin
			@(negedge rclk);
			check_idle_flags();
		end
		rrstn = 1'b1;
		@(negedge wclk);
		wrstn = 1'b1;
		repeat (4) begin
			@(negedge rclk);
			check_idle_flags();
		end
	endtask

	task automatic test_single_order();
		int i;
		$display("test: single-channel order");
		set_hold(1'b0);
		fork
			begin
				for (i = 0; i < 20; i++) begin
					write_cycle(1'b1, cdc_pkg::data_t'($urandom), 1'b0, '0);
				end
				stop_writes();
			end
			begin
				repeat (20) begin
					expect_word(1'b1, 1'b0);
				end
			end
		join
	endtask

	task automatic test_full_drop();
		int i;
		$display("test: full and drop");
		set_hold(1'b1);
		for (i = 0; i < 16; i++) begin
			write_cycle(1'b0, '0, 1'b1, cdc_pkg::data_t'($urandom));
		end
		stop_writes();
		compare_flag("wfull1", 1'b1, wfull1);
		compare_flag("16 words accepted on channel 1", 1'b1, q1.size() == 16);
		for (i = 0; i < 3; i++) begin
			write_cycle(1'b0, '0, 1'b1, cdc_pkg::data_t'($urandom)); // Dropped
			compare_flag("wfull1", 1'b1, wfull1);
		end
		stop_writes();
		set_hold(1'b0);
		repeat (16) begin
			expect_word(1'b1, 1'b1);
		end
		expect_quiet(DRAIN_CYCLES);
	endtask

	task automatic test_round_robin();
		int i;
		$display("test: round-robin fairness");
		set_hold(1'b1);
		for (i = 0; i < 8; i++) begin
			write_cycle(1'b1, cdc_pkg::data_t'($urandom), 1'b1, cdc_pkg::data_t'($urandom));
		end
		stop_writes();
		repeat (SYNC_SETTLE) @(negedge rclk);
		set_hold(1'b0);
		for (i = 0; i < 16; i++) begin
			expect_word(1'b1, cdc_pkg::chan_t'(i % 2));
		end
		expect_quiet(DRAIN_CYCLES);
	endtask

	task automatic test_random_backpressure();
		int i;
		int idle;
		$display("test: random back-pressure");
		wr_done = 1'b0;
		rd_done = 1'b0;
		fork
			begin
				for (i = 0; i < 80; i++) begin
					write_cycle(1'($urandom), cdc_pkg::data_t'($urandom),
						1'($urandom), cdc_pkg::data_t'($urandom));
				end
				stop_writes();
				wr_done = 1'b1;
			end
			begin
				while (!rd_done) begin
					@(negedge rclk);
					dout_hold = 1'($urandom);
				end
			end
			begin
				idle = 0;
				while (!(wr_done && q0.size() == 0 && q1.size() == 0)) begin
					@(negedge rclk);
					if (dout_vld) begin
						take_word(1'b0, 1'b0);
						idle = 0;
					end else begin
						idle++;
						if (idle > IDLE_TIMEOUT) begin
							$display("timeout: output stalled for %0d read cycles", IDLE_TIMEOUT);
							abort_run();
						end
					end
				end
				rd_done = 1'b1;
			end
		join
		set_hold(1'b0);
		expect_quiet(DRAIN_CYCLES);
	endtask

	initial begin
		seed_val = $urandom(SEED);
		rclk = 1'b0;
		wclk = 1'b0;
		rrstn = 1'b0;
		wrstn = 1'b0;
		winc0 = 1'b0;
		wdata0 = '0;
		winc1 = 1'b0;
		wdata1 = '0;
		dout_hold = 1'b0;
		wr_done = 1'b0;
		rd_done = 1'b0;

		test_reset_state();
		test_round_robin(); // First tie right after reset
		test_single_order();
		test_full_drop();
		test_random_backpressure();

		$display("*** PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire

// File: flist.f
+incdir+verilog
+incdir+sim
verilog/cdc_pkg.sv
verilog/dual_port_ram.sv
verilog/async_fifo.sv
verilog/rr_arbiter.sv
verilog/cdc_merge_top.sv
sim/tb_cdc_merge.sv

// File: Makefile
# Verilator build for the two-channel CDC merger

VERILATOR  ?= verilator
TOP        := tb_cdc_merge
RTL_TOP    := cdc_merge_top
FLIST      := flist.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing -j 0
SIM_BIN    := $(OBJ_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

# Lint the design on its own, then together with the testbench
lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FLIST)
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

$(SIM_BIN): $(FLIST) $(shell sed -n '/^[^+]/p' $(FLIST)) sim/tb_checks.svh verilog/cdc_cfg.svh
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# The run exits with a failing status when the testbench stops on an error
sim: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)
